/* hdl/vga_pkg.sv */
// Video timing constants and bus types for the 800x600 at 60 Hz display
// Imported inside the body of every design module
package vga_pkg;

	//------------------------------
	// counter width
	//------------------------------
	localparam int CNT_W = 11;                              // covers 1056 counts

	//------------------------------
	// horizontal timing
	//------------------------------
	localparam logic [CNT_W-1:0] H_SYNC_END  = 11'd128;     // sync pulse width
	localparam logic [CNT_W-1:0] H_ACT_START = 11'd216;     // 128 + 88 back porch
	localparam logic [CNT_W-1:0] H_ACT_END   = 11'd1016;    // + 800 visible
	localparam logic [CNT_W-1:0] H_TOTAL     = 11'd1056;    // + 40 front porch

	//------------------------------
	// vertical timing
	//------------------------------
	localparam logic [CNT_W-1:0] V_SYNC_END  = 11'd4;       // sync pulse lines
	localparam logic [CNT_W-1:0] V_ACT_START = 11'd27;      // 4 + 23 back porch
	localparam logic [CNT_W-1:0] V_ACT_END   = 11'd627;     // + 600 visible
	localparam logic [CNT_W-1:0] V_TOTAL     = 11'd628;     // + 1 front porch

	//------------------------------
	// pixel format
	//------------------------------
	typedef struct packed
	{
		logic [4:0] red;                                    // msb field
		logic [5:0] green;
		logic [4:0] blue;                                   // lsb field
	} pixel_t;                                              // rgb565

	// fill for border and underrun
	localparam pixel_t BORDER_COLOUR = 16'h00F7;

	//------------------------------
	// scan position
	//------------------------------
	typedef struct packed
	{
		logic [CNT_W-1:0] h_cnt;                            // pixel within line
		logic [CNT_W-1:0] v_cnt;                            // line within frame
	} scan_pos_t;

	// what the beam is over at a given count
	typedef enum logic [1:0]
	{
		REGION_BLANK,                                       // porch or sync
		REGION_BORDER,                                      // active, outside picture
		REGION_PICTURE                                      // inside picture window
	} scan_region_e;

endpackage

/* hdl/scan_timing.sv */
// Pixel and line counters for the fixed 800x600 mode with registered sync and active flag
// The count pair goes to the window reader, the flags go straight to the monitor
`timescale 1ns/1ps

module scan_timing
(
	input  logic               CLK_40M,     // pixel clock
	input  logic               RST_N,       // async reset, active low
	output vga_pkg::scan_pos_t pos,         // live counters
	output logic               hsync,       // active low, one cycle behind pos
	output logic               vsync,       // active low, one cycle behind pos
	output logic               de           // active area, one cycle behind pos
);
	import vga_pkg::*;

	logic [CNT_W-1:0] h_cnt;                // pixel counter
	logic [CNT_W-1:0] v_cnt;                // line counter
	logic             h_last;               // last count of line
	logic             v_last;               // last line of frame
	logic             h_act;                // visible columns
	logic             v_act;                // visible lines

	//------------------------------
	// counters
	//------------------------------
	assign h_last = (h_cnt == H_TOTAL - 1'b1);
	assign v_last = (v_cnt == V_TOTAL - 1'b1);

	always_ff @(posedge CLK_40M or negedge RST_N)
	begin
		if (!RST_N)
		begin
			h_cnt <= '0;
		end
		else if (h_last)
		begin
			h_cnt <= '0;                    // wrap at end of line
		end
		else
		begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	always_ff @(posedge CLK_40M or negedge RST_N)
	begin
		if (!RST_N)
		begin
			v_cnt <= '0;
		end
		else if (h_last)
		begin
			if (v_last)
			begin
				v_cnt <= '0;                // wrap at end of frame
			end
			else
			begin
				v_cnt <= v_cnt + 1'b1;      // next line
			end
		end
	end

	assign pos = '{h_cnt: h_cnt, v_cnt: v_cnt};

	//------------------------------
	// sync and active flags
	//------------------------------
	assign h_act = (h_cnt >= H_ACT_START) && (h_cnt < H_ACT_END);
	assign v_act = (v_cnt >= V_ACT_START) && (v_cnt < V_ACT_END);

	// registered so they line up with rgb out of the window reader
	always_ff @(posedge CLK_40M or negedge RST_N)
	begin
		if (!RST_N)
		begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			de    <= 1'b0;
		end
		else
		begin
			hsync <= (h_cnt >= H_SYNC_END); // low during pulse
			vsync <= (v_cnt >= V_SYNC_END); // low during pulse lines
			de    <= h_act && v_act;
		end
	end

endmodule

/* hdl/pixel_cache.sv */
// Show-ahead FIFO between the image source and the window reader
// The head pixel is always visible and a pop consumes the value already shown
`timescale 1ns/1ps

module pixel_cache
#(
	parameter int CACHE_DEPTH = 64                  // entries, power of two
)
(
	input  logic            CLK_40M,                // pixel clock
	input  logic            RST_N,                  // async reset, active low
	input  logic            wr_en,                  // write strobe from source
	input  vga_pkg::pixel_t wr_pixel,               // pixel to store
	input  logic            pop,                    // drop head entry
	output vga_pkg::pixel_t head_pixel,             // oldest entry
	output logic            not_empty,              // head_pixel valid
	output logic            full                    // writes are dropped
);
	import vga_pkg::*;

	localparam int                 PTR_W     = $clog2(CACHE_DEPTH);
	localparam logic [PTR_W:0]     DEPTH_CNT = (PTR_W + 1)'(CACHE_DEPTH);

	pixel_t           mem [CACHE_DEPTH];            // storage, no reset
	logic [PTR_W-1:0] wr_ptr;                       // next free slot
	logic [PTR_W-1:0] rd_ptr;                       // head slot
	logic [PTR_W:0]   count;                        // occupancy
	logic             do_write;                     // accepted write
	logic             do_read;                      // accepted pop

	assign do_write = wr_en && !full;               // overflow discarded
	assign do_read  = pop && not_empty;

	//------------------------------
	// storage
	//------------------------------
	always_ff @(posedge CLK_40M)
	begin
		if (do_write)
		begin
			mem[wr_ptr] <= wr_pixel;
		end
	end

	assign head_pixel = mem[rd_ptr];                // show-ahead read

	//------------------------------
	// pointers and level
	//------------------------------
	always_ff @(posedge CLK_40M or negedge RST_N)
	begin
		if (!RST_N)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_write)
			begin
				wr_ptr <= wr_ptr + 1'b1;            // wraps on power of two
			end
			if (do_read)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;            // none or both
			endcase
		end
	end

	assign not_empty = (count != '0);
	assign full      = (count == DEPTH_CNT);        // falls the cycle after a pop

endmodule

/* hdl/window_reader.sv */
// Places the picture window inside the active area and registers the output colour
// Pops the pixel cache for every picture position that finds it not empty
`timescale 1ns/1ps

module window_reader
#(
	parameter int PIC_W = 240,                      // picture width
	parameter int PIC_H = 320,                      // picture height
	parameter int PIC_X = 280,                      // offset from first visible pixel
	parameter int PIC_Y = 140                       // offset from first visible line
)
(
	input  logic               CLK_40M,             // pixel clock
	input  logic               RST_N,               // async reset, active low
	input  vga_pkg::scan_pos_t pos,                 // live counters
	input  vga_pkg::pixel_t    head_pixel,          // cache head
	input  logic               not_empty,           // head valid
	output logic               pop,                 // head consumed this edge
	output vga_pkg::pixel_t    rgb                  // registered colour
);
	import vga_pkg::*;

	// picture window in absolute counts
	localparam logic [CNT_W-1:0] PIC_H_START = CNT_W'(H_ACT_START + PIC_X);
	localparam logic [CNT_W-1:0] PIC_H_END   = CNT_W'(H_ACT_START + PIC_X + PIC_W);
	localparam logic [CNT_W-1:0] PIC_V_START = CNT_W'(V_ACT_START + PIC_Y);
	localparam logic [CNT_W-1:0] PIC_V_END   = CNT_W'(V_ACT_START + PIC_Y + PIC_H);

	logic         h_act;                            // visible column
	logic         v_act;                            // visible line
	logic         h_pic;                            // picture column
	logic         v_pic;                            // picture line
	scan_region_e region;                           // class of current pos

	//------------------------------
	// region decode
	//------------------------------
	assign h_act = (pos.h_cnt >= H_ACT_START) && (pos.h_cnt < H_ACT_END);
	assign v_act = (pos.v_cnt >= V_ACT_START) && (pos.v_cnt < V_ACT_END);
	assign h_pic = (pos.h_cnt >= PIC_H_START) && (pos.h_cnt < PIC_H_END);
	assign v_pic = (pos.v_cnt >= PIC_V_START) && (pos.v_cnt < PIC_V_END);

	always_comb
	begin
		if (!(h_act && v_act))
		begin
			region = REGION_BLANK;
		end
		else if (h_pic && v_pic)
		begin
			region = REGION_PICTURE;
		end
		else
		begin
			region = REGION_BORDER;
		end
	end

	// cache drops the head on the same edge that rgb takes it
	assign pop = (region == REGION_PICTURE) && not_empty;

	//------------------------------
	// colour register
	//------------------------------
	always_ff @(posedge CLK_40M or negedge RST_N)
	begin
		if (!RST_N)
		begin
			rgb <= '0;
		end
		else
		begin
			case (region)
				REGION_PICTURE: rgb <= not_empty ? head_pixel : BORDER_COLOUR; // underrun fill
				REGION_BORDER:  rgb <= BORDER_COLOUR;
				default:        rgb <= '0;          // blanking
			endcase
		end
	end

endmodule

/* hdl/vga_display.sv */
// Top level of the VGA display path with scan timing, pixel cache and window reader
// The image source writes pixels in raster order through wr_en and wr_pixel
`timescale 1ns/1ps

module vga_display
#(
	parameter int PIC_W       = 240,            // picture width
	parameter int PIC_H       = 320,            // picture height
	parameter int PIC_X       = 280,            // x offset in active area
	parameter int PIC_Y       = 140,            // y offset in active area
	parameter int CACHE_DEPTH = 64              // cache entries, power of two
)
(
	input  logic            CLK_40M,            // pixel clock
	input  logic            RST_N,              // async reset, active low
	input  logic            wr_en,              // source write strobe
	input  vga_pkg::pixel_t wr_pixel,           // source pixel
	output logic            full,               // cache full
	output logic            hsync,              // to monitor
	output logic            vsync,              // to monitor
	output logic            de,                 // active area
	output vga_pkg::pixel_t rgb                 // colour out
);
	import vga_pkg::*;

	scan_pos_t pos;                             // counter pair
	pixel_t    head_pixel;                      // cache head
	logic      not_empty;                       // cache has data
	logic      pop;                             // head consumed

	//------------------------------
	// scan timing
	//------------------------------
	scan_timing u_scan_timing
	(
		.CLK_40M (CLK_40M),
		.RST_N   (RST_N),
		.pos     (pos),
		.hsync   (hsync),
		.vsync   (vsync),
		.de      (de)
	);

	//------------------------------
	// pixel cache
	//------------------------------
	pixel_cache #(
		.CACHE_DEPTH (CACHE_DEPTH)
	) u_pixel_cache (
		.CLK_40M    (CLK_40M),
		.RST_N      (RST_N),
		.wr_en      (wr_en),
		.wr_pixel   (wr_pixel),
		.pop        (pop),
		.head_pixel (head_pixel),
		.not_empty  (not_empty),
		.full       (full)
	);

	//------------------------------
	// window reader
	//------------------------------
	window_reader #(
		.PIC_W (PIC_W),
		.PIC_H (PIC_H),
		.PIC_X (PIC_X),
		.PIC_Y (PIC_Y)
	) u_window_reader (
		.CLK_40M    (CLK_40M),
		.RST_N      (RST_N),
		.pos        (pos),
		.head_pixel (head_pixel),
		.not_empty  (not_empty),
		.pop        (pop),
		.rgb        (rgb)
	);

endmodule

/* sim/tb_vga_display.sv */
// Testbench for the VGA display path, one full frame per table row
// Writes pixels during vsync, then checks sync shape, active area and picture content
`timescale 1ns/1ps

module tb_vga_display;
	import vga_pkg::*;

	//------------------------------
	// bench constants
	//------------------------------
	localparam int NUM_ROWS      = 4;
	localparam int DEPTH         = 32;                      // cache entries under test
	localparam int FRAME_CYCLES  = 1056 * 628;              // H_TOTAL x V_TOTAL
	localparam int LINE_CYCLES   = 1056;
	localparam int PIC_COL_FIRST = 216 + 280;               // first picture column
	localparam int PIC_COL_LAST  = 216 + 280 + 8;           // one past last column
	localparam int PIC_ROW_FIRST = 27 + 140;                // first picture line
	localparam int PIC_ROW_LAST  = 27 + 140 + 4;            // one past last line
	localparam longint WATCHDOG_NS = longint'(NUM_ROWS + 2) * FRAME_CYCLES * 40;

	typedef struct packed
	{
		logic [63:0] name;                                  // ascii right aligned
		int          n_write;                               // pixels sent this frame
		int          exp_shown;                             // picture pixels from data
		int          exp_dropped;                           // writes lost to full
	} row_t;

	logic   CLK_40M;
	logic   RST_N;
	logic   wr_en;
	pixel_t wr_pixel;
	logic   full;
	logic   hsync;
	logic   vsync;
	logic   de;
	pixel_t rgb;

	row_t   rows [NUM_ROWS];                                // stimulus table
	pixel_t ref_q [$];                                      // pixels sent this frame
	string  cur_name;
	integer seed;
	int     errors;
	int     tests_failed;
	int     frame_cycle;                                    // position of sampled outputs
	int     cur_exp_shown;
	logic   mon_on;

	// monitor counters, cleared per frame
	int     hs_low;
	int     hs_runs;
	int     bad_lines;
	int     vs_low_samples;
	int     vs_low_lines;
	int     de_count;
	int     blank_nonzero;
	int     border_errors;
	int     shown;
	logic   prev_hs;
	logic   full_seen;

	vga_display #(
		.PIC_W       (8),
		.PIC_H       (4),
		.PIC_X       (280),
		.PIC_Y       (140),
		.CACHE_DEPTH (DEPTH)
	) DUT (
		.CLK_40M  (CLK_40M),
		.RST_N    (RST_N),
		.wr_en    (wr_en),
		.wr_pixel (wr_pixel),
		.full     (full),
		.hsync    (hsync),
		.vsync    (vsync),
		.de       (de),
		.rgb      (rgb)
	);

	initial CLK_40M = 1'b0;
	always #20 CLK_40M = ~CLK_40M;                          // 40 ns period

	//------------------------------
	// helpers
	//------------------------------
	task automatic check_value(input string what, input int expected, input int actual);
		if (expected !== actual)
		begin
			$display("FAIL %s %s: expected %0d (0x%0h), actual %0d (0x%0h)",
				cur_name, what, expected, expected, actual, actual);
			errors++;
		end
	endtask

	function automatic string name_text(input logic [63:0] packed_name);
		string s;
		s = "";
		for (int i = 7; i >= 0; i--)
		begin
			if (packed_name[i*8 +: 8] != 8'h00)
			begin
				s = $sformatf("%s%c", s, packed_name[i*8 +: 8]); // skip pad bytes
			end
		end
		return s;
	endfunction

	task automatic load_table();
		rows[0] = '{"exact", 32, 32, 0};                   // fills the picture exactly
		rows[1] = '{"short", 20, 20, 0};                   // underrun leaves 12 border pixels
		rows[2] = '{"over",  40, 32, 8};                   // last 8 dropped at full
		rows[3] = '{"after", 32, 32, 0};                   // no leftovers from "over"
	endtask

	task automatic report_test(input int errors_before);
		if (errors == errors_before)
		begin
			$display("test %s: ok", cur_name);
		end
		else
		begin
			$display("test %s: %0d errors", cur_name, errors - errors_before);
			tests_failed++;
		end
	endtask

	task automatic clear_counts();
		hs_low = 0;
		hs_runs = 0;
		bad_lines = 0;
		vs_low_samples = 0;
		vs_low_lines = 0;
		de_count = 0;
		blank_nonzero = 0;
		border_errors = 0;
		shown = 0;
		prev_hs = 1'b1;
		full_seen = 1'b0;
	endtask

	//------------------------------
	// one frame per table row
	//------------------------------
	task automatic run_frame(input int r);
		int     n_written;
		int     dropped;
		integer raw;
		n_written = 0;
		dropped = 0;
		ref_q.delete();
		clear_counts();
		cur_exp_shown = rows[r].exp_shown;
		for (int cyc = 0; cyc < FRAME_CYCLES; cyc++)
		begin
			@(posedge CLK_40M);
			#1;
			frame_cycle = cyc;                              // outputs now describe this count
			mon_on = 1'b1;
			wr_en = 1'b0;
			if (!vsync && n_written < rows[r].n_write)
			begin
				raw = $random(seed);
				wr_pixel = raw[15:0];
				wr_en = 1'b1;
				ref_q.push_back(raw[15:0]);
				if (full)
				begin
					dropped++;                              // cache ignores this one
				end
				n_written++;
			end
		end
		wr_en = 1'b0;
		@(negedge CLK_40M);                                 // last sample taken
		#1;
		mon_on = 1'b0;
		check_value("hsync bad lines", 0, bad_lines);
		check_value("vsync low samples", 4 * LINE_CYCLES, vs_low_samples);
		check_value("vsync low lines", 4, vs_low_lines);
		check_value("de high samples", 800 * 600, de_count);
		check_value("rgb outside de", 0, blank_nonzero);
		check_value("border pixels", 0, border_errors);
		check_value("shown pixels", rows[r].exp_shown, shown);
		check_value("dropped writes", rows[r].exp_dropped, dropped);
		check_value("full seen", int'(rows[r].n_write >= DEPTH), int'(full_seen));
		check_value("full at frame end", 0, int'(full));  // cache drained
	endtask

	//------------------------------
	// monitor
	//------------------------------
	always @(negedge CLK_40M)
	begin
		int     h;
		int     v;
		int     p;
		pixel_t exp_pix;
		if (mon_on)
		begin
			h = frame_cycle % LINE_CYCLES;
			v = frame_cycle / LINE_CYCLES;
			if (h == 0)
			begin
				hs_low = 0;
				hs_runs = 0;
				prev_hs = 1'b1;
			end
			if (!hsync)
			begin
				hs_low++;
				if (prev_hs)
				begin
					hs_runs++;                              // start of a low run
				end
			end
			prev_hs = hsync;
			if (h == LINE_CYCLES - 1 && (hs_low != 128 || hs_runs != 1))
			begin
				bad_lines++;
			end
			if (!vsync)
			begin
				vs_low_samples++;
			end
			if (h == 0 && !vsync)
			begin
				vs_low_lines++;
			end
			if (full)
			begin
				full_seen = 1'b1;
			end
			if (!de)
			begin
				if (rgb != '0)
				begin
					blank_nonzero++;
				end
			end
			else if (h >= PIC_COL_FIRST && h < PIC_COL_LAST &&
				v >= PIC_ROW_FIRST && v < PIC_ROW_LAST)
			begin
				de_count++;
				p = (v - PIC_ROW_FIRST) * 8 + (h - PIC_COL_FIRST); // raster index
				exp_pix = (p < cur_exp_shown) ? ref_q[p] : BORDER_COLOUR;
				check_value($sformatf("picture pixel %0d", p), int'(exp_pix), int'(rgb));
				if (p < ref_q.size() && rgb == ref_q[p])
				begin
					shown++;
				end
			end
			else
			begin
				de_count++;
				if (rgb != BORDER_COLOUR)
				begin
					border_errors++;
				end
			end
		end
	end

	//------------------------------
	// watchdog
	//------------------------------
	initial
	begin
		#(WATCHDOG_NS);
		$display("simulation timed out before all frames finished");
		$display("** FAIL **");
		$finish;
	end

	//------------------------------
	// main sequence
	//------------------------------
	initial
	begin
		int errors_before;
		RST_N = 1'b0;
		wr_en = 1'b0;
		wr_pixel = '0;
		seed = 32'he393;
		errors = 0;
		tests_failed = 0;
		frame_cycle = 0;
		cur_exp_shown = 0;
		mon_on = 1'b0;
		clear_counts();
		load_table();

		cur_name = "reset";
		errors_before = errors;
		repeat (4)
		begin
			@(posedge CLK_40M);
			#1;
			check_value("hsync", 0, int'(hsync));
			check_value("vsync", 0, int'(vsync));
			check_value("de", 0, int'(de));
			check_value("rgb", 0, int'(rgb));
			check_value("full", 0, int'(full));
		end
		report_test(errors_before);
		RST_N = 1'b1;                                       // next edge starts frame 0

		for (int r = 0; r < NUM_ROWS; r++)
		begin
			cur_name = name_text(rows[r].name);
			errors_before = errors;
			run_frame(r);
			report_test(errors_before);
		end

		$display("tests run %0d, failed %0d, errors %0d", NUM_ROWS + 1, tests_failed, errors);
		if (errors == 0)
		begin
			$display("** PASS **");
		end
		else
		begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* vga_display.f */
hdl/vga_pkg.sv
hdl/scan_timing.sv
hdl/pixel_cache.sv
hdl/window_reader.sv
hdl/vga_display.sv
sim/tb_vga_display.sv
